// ==== hdl/periph_map_pkg.sv ====
/* Bus types and address map of the peripheral subsystem.
   Region in addr[11:8]; peers decode only the low 8 offset bits */
`default_nettype none

package periph_map_pkg;

    // ------------------------------------------------------------------------
    // Register bus
    // ------------------------------------------------------------------------
    localparam int ADDR_W = 12;
    localparam int DATA_W = 32;
    localparam int OFS_W  = 8;                  // Offset bits inside a region

    typedef enum logic {
        BUS_READ  = 1'b0,
        BUS_WRITE = 1'b1
    } bus_op_e;

    typedef struct packed {
        logic              valid;               // One-cycle strobe
        bus_op_e           op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic              ready;               // Exactly one cycle after valid
        logic              error;               // Unmapped region
        logic [DATA_W-1:0] rdata;
    } bus_resp_t;

    typedef logic [DATA_W-1:0] peer_rdata_t;

    // ------------------------------------------------------------------------
    // Address map
    // ------------------------------------------------------------------------
    typedef enum logic [ADDR_W-OFS_W-1:0] {
        REGION_GPIO = 4'd0,
        REGION_RNG  = 4'd1,
        REGION_IRQ  = 4'd2
    } region_e;

    localparam logic [OFS_W-1:0] GPIO_LEDS_OFS  = 8'h00;
    localparam logic [OFS_W-1:0] GPIO_DIP_OFS   = 8'h04;
    localparam logic [OFS_W-1:0] GPIO_MASK_OFS  = 8'h08;
    localparam logic [OFS_W-1:0] RNG_DATA_OFS   = 8'h00;   // Read pops the FIFO
    localparam logic [OFS_W-1:0] RNG_STATUS_OFS = 8'h04;

    localparam logic [DATA_W-1:0] BAD_DATA = 32'hDEAD_BEEF;

    // Random source
    localparam logic [DATA_W-1:0] RNG_SEED  = 32'hACE1_2468;
    localparam logic [DATA_W-1:0] RNG_TAPS  = 32'h8020_0003;
    localparam int                RNG_DEPTH = 8;
    localparam int                RNG_PTR_W = $clog2(RNG_DEPTH);
    localparam int                RNG_CNT_W = $clog2(RNG_DEPTH + 1);

endpackage

`default_nettype wire

// ==== hdl/periph_irq_pkg.sv ====
/* Interrupt controller sizes and register layout.
   Source id 0 means none; irq_src_t bit 0 carries source id 1 */
`default_nettype none

package periph_irq_pkg;

    // ------------------------------------------------------------------------
    // Sizes
    // ------------------------------------------------------------------------
    localparam int NUM_SOURCES = 2;
    localparam int NUM_TARGETS = 2;
    localparam int PRIO_W      = 3;
    localparam int SRC_ID_W    = $clog2(NUM_SOURCES + 1);

    typedef logic [NUM_SOURCES-1:0] irq_src_t;     // Level per source

    typedef enum logic [1:0] {
        GW_IDLE    = 2'd0,
        GW_PENDING = 2'd1,
        GW_SERVICE = 2'd2                            // Claimed and waiting for complete
    } gw_state_e;

    // ------------------------------------------------------------------------
    // Register offsets, one word per entry
    // ------------------------------------------------------------------------
    localparam logic [7:0] IRQ_PRIO_OFS   = 8'h00;   // Word per source id
    localparam logic [7:0] IRQ_ENABLE_OFS = 8'h20;   // Word per target
    localparam logic [7:0] IRQ_THRESH_OFS = 8'h40;
    localparam logic [7:0] IRQ_CLAIM_OFS  = 8'h60;   // A read claims and a write completes

endpackage

`default_nettype wire

// ==== hdl/periph_decoder.sv ====
/* Single-master address decoder. No back-pressure: every request
   gets its response exactly one cycle later */
`default_nettype none

module periph_decoder import periph_map_pkg::*;
(
    input  logic        clk_i,
    input  logic        reset_i,
    input  bus_req_t    req_i,
    output bus_resp_t   resp_o,
    output bus_req_t    gpio_req_o,
    output bus_req_t    rng_req_o,
    output bus_req_t    irq_req_o,
    input  peer_rdata_t gpio_rdata_i,
    input  peer_rdata_t rng_rdata_i,
    input  peer_rdata_t irq_rdata_i
);

    logic [ADDR_W-OFS_W-1:0] region_field;
    region_e                 sel_region;
    logic                    sel_hit;

    logic    valid_q;
    logic    hit_q;
    region_e region_q;

    assign region_field = req_i.addr[ADDR_W-1:OFS_W];

    always_comb
    begin
        sel_region = REGION_GPIO;
        sel_hit    = 1'b1;
        case (region_field)
            REGION_GPIO: sel_region = REGION_GPIO;
            REGION_RNG:  sel_region = REGION_RNG;
            REGION_IRQ:  sel_region = REGION_IRQ;
            default:     sel_hit    = 1'b0;    // Regions 3 to 15
        endcase
    end

    // Payload goes to every peer but valid only to the selected one
    always_comb
    begin
        gpio_req_o       = req_i;
        rng_req_o        = req_i;
        irq_req_o        = req_i;
        gpio_req_o.valid = req_i.valid && sel_hit && (sel_region == REGION_GPIO);
        rng_req_o.valid  = req_i.valid && sel_hit && (sel_region == REGION_RNG);
        irq_req_o.valid  = req_i.valid && sel_hit && (sel_region == REGION_IRQ);
    end

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            valid_q  <= 1'b0;
            hit_q    <= 1'b0;
            region_q <= REGION_GPIO;
        end
        else
        begin
            valid_q  <= req_i.valid;
            hit_q    <= sel_hit;
            region_q <= sel_region;
        end
    end

    // Response stage
    always_comb
    begin
        resp_o.ready = valid_q;
        resp_o.error = valid_q && !hit_q;
        if (!hit_q)
            resp_o.rdata = BAD_DATA;
        else
        begin
            case (region_q)
                REGION_RNG: resp_o.rdata = rng_rdata_i;
                REGION_IRQ: resp_o.rdata = irq_rdata_i;
                default:    resp_o.rdata = gpio_rdata_i;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/gpio_regs.sv ====
/* LED and interrupt mask registers plus DIP switch input.
   Interrupt is a level, combinational from mask and switches */
`default_nettype none

module gpio_regs import periph_map_pkg::*;
(
    input  logic        clk_i,
    input  logic        reset_i,
    input  bus_req_t    req_i,
    output peer_rdata_t rdata_o,
    input  logic [7:0]  dip_switches_i,
    output logic [7:0]  leds_o,
    output logic        irq_o
);

    logic [OFS_W-1:0] ofs;
    logic             rd_en;
    logic             wr_en;
    logic [7:0]       mask_q;
    peer_rdata_t      rd_word;

    assign ofs   = req_i.addr[OFS_W-1:0];
    assign rd_en = req_i.valid && (req_i.op == BUS_READ);
    assign wr_en = req_i.valid && (req_i.op == BUS_WRITE);

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            leds_o <= '0;
            mask_q <= '0;
        end
        else if (wr_en)
        begin
            if (ofs == GPIO_LEDS_OFS)
                leds_o <= req_i.wdata[7:0];
            if (ofs == GPIO_MASK_OFS)
                mask_q <= req_i.wdata[7:0];
        end
    end

    always_comb
    begin
        case (ofs)
            GPIO_LEDS_OFS: rd_word = DATA_W'(leds_o);
            GPIO_DIP_OFS:  rd_word = DATA_W'(dip_switches_i);
            GPIO_MASK_OFS: rd_word = DATA_W'(mask_q);
            default:       rd_word = '0;
        endcase
    end

    // Held for the decoder's response cycle; writes return zero
    always_ff @(posedge clk_i)
    begin
        rdata_o <= rd_en ? rd_word : '0;
    end

    assign irq_o = |(dip_switches_i & mask_q);

endmodule

`default_nettype wire

// ==== hdl/rng_fifo.sv ====
/* Galois LFSR feeding an 8-deep FIFO; not a secure random source.
   Pushes every cycle the FIFO is not full. Writes are ignored */
`default_nettype none

module rng_fifo import periph_map_pkg::*;
(
    input  logic        clk_i,
    input  logic        reset_i,
    input  bus_req_t    req_i,
    output peer_rdata_t rdata_o,
    output logic        full_o
);

    logic [OFS_W-1:0]     ofs;
    logic                 rd_en;
    logic [DATA_W-1:0]    lfsr_q;
    logic [DATA_W-1:0]    lfsr_next;

    logic [DATA_W-1:0]    mem [RNG_DEPTH];
    logic [RNG_PTR_W-1:0] wr_ptr_q;
    logic [RNG_PTR_W-1:0] rd_ptr_q;
    logic [RNG_CNT_W-1:0] count_q;
    logic                 empty;
    logic                 push;
    logic                 pop;
    peer_rdata_t          rd_word;

    assign ofs   = req_i.addr[OFS_W-1:0];
    assign rd_en = req_i.valid && (req_i.op == BUS_READ);

    // ------------------------------------------------------------------------
    // Random source
    // ------------------------------------------------------------------------
    assign lfsr_next = lfsr_q[0] ? ((lfsr_q >> 1) ^ RNG_TAPS) : (lfsr_q >> 1);

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
            lfsr_q <= RNG_SEED;
        else if (push)
            lfsr_q <= lfsr_next;                // Steps only when a word is taken
    end

    // ------------------------------------------------------------------------
    // FIFO
    // ------------------------------------------------------------------------
    assign full_o = (count_q == RNG_CNT_W'(RNG_DEPTH));
    assign empty  = (count_q == '0);
    assign push   = !full_o;
    assign pop    = rd_en && (ofs == RNG_DATA_OFS) && !empty;

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr_q <= wr_ptr_q + 1'b1;    // Wraps at depth 8
            if (pop)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            if (push && !pop)
                count_q <= count_q + 1'b1;
            else if (pop && !push)
                count_q <= count_q - 1'b1;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (push)
            mem[wr_ptr_q] <= lfsr_q;
    end

    always_comb
    begin
        case (ofs)
            RNG_DATA_OFS:   rd_word = empty ? '0 : mem[rd_ptr_q];
            RNG_STATUS_OFS: rd_word = {full_o, empty, {(DATA_W-2-RNG_CNT_W){1'b0}}, count_q};
            default:        rd_word = '0;
        endcase
    end

    always_ff @(posedge clk_i)
    begin
        rdata_o <= rd_en ? rd_word : '0;
    end

endmodule

`default_nettype wire

// ==== hdl/irq_controller.sv ====
/* Level-only interrupt controller with claim and complete per target.
   Priority must exceed the target threshold; ties go to the lower id */
`default_nettype none

module irq_controller
    import periph_map_pkg::*;
    import periph_irq_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  bus_req_t               req_i,
    output peer_rdata_t            rdata_o,
    input  irq_src_t               sources_i,
    output logic [NUM_TARGETS-1:0] irq_o
);

    logic [OFS_W-1:0]    ofs;
    logic [2:0]          grp;                   // Register group from ofs[7:5]
    logic [2:0]          idx;                   // Word within the group
    logic                rd_en;
    logic                wr_en;

    logic [PRIO_W-1:0]   prio_q   [NUM_SOURCES];
    irq_src_t            en_q     [NUM_TARGETS];
    logic [PRIO_W-1:0]   thresh_q [NUM_TARGETS];
    gw_state_e           gw_q     [NUM_SOURCES];

    logic [SRC_ID_W-1:0] cand_id  [NUM_TARGETS];
    irq_src_t            claim_take;
    irq_src_t            complete;
    peer_rdata_t         rd_word;

    assign ofs   = req_i.addr[OFS_W-1:0];
    assign grp   = ofs[7:5];
    assign idx   = ofs[4:2];
    assign rd_en = req_i.valid && (req_i.op == BUS_READ);
    assign wr_en = req_i.valid && (req_i.op == BUS_WRITE);

    // ------------------------------------------------------------------------
    // Candidate per target
    // ------------------------------------------------------------------------
    always_comb
    begin
        logic [PRIO_W-1:0] best_prio;
        for (int t = 0; t < NUM_TARGETS; t++)
        begin
            best_prio  = thresh_q[t];
            cand_id[t] = '0;
            for (int s = 0; s < NUM_SOURCES; s++)
            begin
                // Strict compare keeps the lower id on a tie
                if (gw_q[s] == GW_PENDING && en_q[t][s] && prio_q[s] > best_prio)
                begin
                    best_prio  = prio_q[s];
                    cand_id[t] = SRC_ID_W'(s + 1);
                end
            end
        end
    end

    // Claim reads and complete writes decoded per source
    always_comb
    begin
        claim_take = '0;
        complete   = '0;
        for (int s = 0; s < NUM_SOURCES; s++)
        begin
            for (int t = 0; t < NUM_TARGETS; t++)
            begin
                if (rd_en && grp == IRQ_CLAIM_OFS[7:5] && idx == t
                    && cand_id[t] == SRC_ID_W'(s + 1))
                    claim_take[s] = 1'b1;
            end
            if (wr_en && grp == IRQ_CLAIM_OFS[7:5] && idx < NUM_TARGETS
                && req_i.wdata == DATA_W'(s + 1))
                complete[s] = 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Gateways and configuration registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            for (int s = 0; s < NUM_SOURCES; s++)
            begin
                gw_q[s]   <= GW_IDLE;
                prio_q[s] <= '0;
            end
            for (int t = 0; t < NUM_TARGETS; t++)
            begin
                en_q[t]     <= '0;
                thresh_q[t] <= '0;
            end
            irq_o <= '0;
        end
        else
        begin
            for (int s = 0; s < NUM_SOURCES; s++)
            begin
                case (gw_q[s])
                    GW_IDLE:    if (sources_i[s])  gw_q[s] <= GW_PENDING;
                    GW_PENDING: if (claim_take[s]) gw_q[s] <= GW_SERVICE;
                    GW_SERVICE: if (complete[s])   gw_q[s] <= GW_IDLE;
                    default:    gw_q[s] <= GW_IDLE;
                endcase
                if (wr_en && grp == IRQ_PRIO_OFS[7:5] && idx == s + 1)
                    prio_q[s] <= req_i.wdata[PRIO_W-1:0];
            end
            for (int t = 0; t < NUM_TARGETS; t++)
            begin
                if (wr_en && grp == IRQ_ENABLE_OFS[7:5] && idx == t)
                    en_q[t] <= req_i.wdata[NUM_SOURCES:1];  // Bit s is source id s
                if (wr_en && grp == IRQ_THRESH_OFS[7:5] && idx == t)
                    thresh_q[t] <= req_i.wdata[PRIO_W-1:0];
                irq_o[t] <= (cand_id[t] != '0);
            end
        end
    end

    // ------------------------------------------------------------------------
    // Read back
    // ------------------------------------------------------------------------
    always_comb
    begin
        rd_word = '0;
        for (int s = 0; s < NUM_SOURCES; s++)
        begin
            if (grp == IRQ_PRIO_OFS[7:5] && idx == s + 1)
                rd_word = DATA_W'(prio_q[s]);
        end
        for (int t = 0; t < NUM_TARGETS; t++)
        begin
            if (idx == t)
            begin
                if (grp == IRQ_ENABLE_OFS[7:5])
                    rd_word = DATA_W'({en_q[t], 1'b0});
                else if (grp == IRQ_THRESH_OFS[7:5])
                    rd_word = DATA_W'(thresh_q[t]);
                else if (grp == IRQ_CLAIM_OFS[7:5])
                    rd_word = DATA_W'(cand_id[t]);   // 0 when nothing qualifies
            end
        end
    end

    always_ff @(posedge clk_i)
    begin
        rdata_o <= rd_en ? rd_word : '0;
    end

endmodule

`default_nettype wire

// ==== hdl/periph_top.sv ====
/* Peripheral subsystem with a decoder and GPIO, RNG and interrupt peers.
   Interrupt sources are level only */
`default_nettype none

module periph_top
    import periph_map_pkg::*;
    import periph_irq_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  bus_req_t               req_i,
    output bus_resp_t              resp_o,
    input  logic [7:0]             dip_switches_i,
    output logic [7:0]             leds_o,
    output logic [NUM_TARGETS-1:0] irq_o
);

    bus_req_t    gpio_req;
    bus_req_t    rng_req;
    bus_req_t    irq_req;
    peer_rdata_t gpio_rdata;
    peer_rdata_t rng_rdata;
    peer_rdata_t irq_rdata;
    irq_src_t    irq_sources;

    periph_decoder periph_decoder_inst (
        .clk_i        ( clk_i      ),
        .reset_i      ( reset_i    ),
        .req_i        ( req_i      ),
        .resp_o       ( resp_o     ),
        .gpio_req_o   ( gpio_req   ),
        .rng_req_o    ( rng_req    ),
        .irq_req_o    ( irq_req    ),
        .gpio_rdata_i ( gpio_rdata ),
        .rng_rdata_i  ( rng_rdata  ),
        .irq_rdata_i  ( irq_rdata  )
    );

    gpio_regs gpio_regs_inst (
        .clk_i          ( clk_i          ),
        .reset_i        ( reset_i        ),
        .req_i          ( gpio_req       ),
        .rdata_o        ( gpio_rdata     ),
        .dip_switches_i ( dip_switches_i ),
        .leds_o         ( leds_o         ),
        .irq_o          ( irq_sources[0] )  // Source id 1
    );

    rng_fifo rng_fifo_inst (
        .clk_i   ( clk_i          ),
        .reset_i ( reset_i        ),
        .req_i   ( rng_req        ),
        .rdata_o ( rng_rdata      ),
        .full_o  ( irq_sources[1] )         // Source id 2
    );

    irq_controller irq_controller_inst (
        .clk_i     ( clk_i       ),
        .reset_i   ( reset_i     ),
        .req_i     ( irq_req     ),
        .rdata_o   ( irq_rdata   ),
        .sources_i ( irq_sources ),
        .irq_o     ( irq_o       )
    );

endmodule

`default_nettype wire

// ==== tests/periph_model.svh ====
/* Cycle model of the subsystem, stepped once per clock edge.
   Level interrupt sources only; offsets are taken word aligned */
`ifndef PERIPH_MODEL_SVH
`define PERIPH_MODEL_SVH

logic [7:0]  m_leds;
logic [7:0]  m_mask;
logic [31:0] m_lfsr;
logic [31:0] m_fifo [$];
logic [2:0]  m_prio   [2];
logic [1:0]  m_en     [2];                      // Bit 0 is source id 1
logic [2:0]  m_thresh [2];
gw_state_e   m_gw     [2];
logic [1:0]  m_irq;

function automatic logic [31:0] lfsr_advance(input logic [31:0] v);
    return v[0] ? ((v >> 1) ^ RNG_TAPS) : (v >> 1);
endfunction

task automatic reset_model();
    m_leds = '0;
    m_mask = '0;
    m_lfsr = RNG_SEED;
    m_fifo.delete();
    m_irq  = '0;
    for (int i = 0; i < 2; i++)
    begin
        m_prio[i]   = '0;
        m_en[i]     = '0;
        m_thresh[i] = '0;
        m_gw[i]     = GW_IDLE;
    end
endtask

// Highest priority above the threshold wins and a tie goes to the lowest id
function automatic int pick_candidate(input int t);
    int best;
    int id;
    best = m_thresh[t];
    id   = 0;
    for (int s = 0; s < 2; s++)
    begin
        if (m_gw[s] == GW_PENDING && m_en[t][s] && int'(m_prio[s]) > best)
        begin
            best = m_prio[s];
            id   = s + 1;
        end
    end
    return id;
endfunction

// ---------------------------------------------------------------------------
// One clock edge with request r and switches d
// ---------------------------------------------------------------------------
task automatic step_model(input bus_req_t r, input logic [7:0] d, output bus_resp_t exp);
    int          region;
    int          ofs;
    int          grp;
    int          idx;
    int          count;
    int          cand [2];
    logic [1:0]  src;
    logic        rd;
    logic        wr;
    logic [31:0] rdata;
    region = r.addr[11:8];
    ofs    = r.addr[7:0];
    grp    = ofs / 32;
    idx    = (ofs % 32) / 4;
    count  = m_fifo.size();
    for (int t = 0; t < 2; t++)
        cand[t] = pick_candidate(t);
    src[0] = |(d & m_mask);
    src[1] = (count == RNG_DEPTH);
    rd     = r.valid && r.op == BUS_READ;
    wr     = r.valid && r.op == BUS_WRITE;
    rdata  = '0;
    if (region > 2)
        rdata = BAD_DATA;
    else if (rd && region == 0)
        rdata = (ofs == 0) ? 32'(m_leds) : (ofs == 4) ? 32'(d) : (ofs == 8) ? 32'(m_mask) : 0;
    else if (rd && region == 1 && ofs == 0)
        rdata = (count == 0) ? 32'h0 : m_fifo[0];
    else if (rd && region == 1 && ofs == 4)
        rdata = {count == RNG_DEPTH, count == 0, 26'b0, 4'(count)};
    else if (rd && region == 2)
    begin
        if (grp == 0 && (idx == 1 || idx == 2))
            rdata = 32'(m_prio[idx-1]);
        else if (grp == 1 && idx < 2)
            rdata = 32'({m_en[idx], 1'b0});
        else if (grp == 2 && idx < 2)
            rdata = 32'(m_thresh[idx]);
        else if (grp == 3 && idx < 2)
            rdata = 32'(cand[idx]);
    end
    exp.ready = r.valid;
    exp.error = r.valid && region > 2;
    exp.rdata = rdata;

    if (wr && region == 0 && ofs == 0)
        m_leds = r.wdata[7:0];
    if (wr && region == 0 && ofs == 8)
        m_mask = r.wdata[7:0];
    for (int s = 0; s < 2; s++)
    begin
        if (m_gw[s] == GW_IDLE && src[s])
            m_gw[s] = GW_PENDING;
        else if (m_gw[s] == GW_PENDING && rd && region == 2 && grp == 3 && idx < 2
                 && cand[idx] == s + 1)
            m_gw[s] = GW_SERVICE;
        else if (m_gw[s] == GW_SERVICE && wr && region == 2 && grp == 3 && idx < 2
                 && r.wdata == 32'(s + 1))
            m_gw[s] = GW_IDLE;
    end
    if (wr && region == 2 && grp == 0 && (idx == 1 || idx == 2))
        m_prio[idx-1] = r.wdata[2:0];
    if (wr && region == 2 && grp == 1 && idx < 2)
        m_en[idx] = r.wdata[2:1];
    if (wr && region == 2 && grp == 2 && idx < 2)
        m_thresh[idx] = r.wdata[2:0];
    for (int t = 0; t < 2; t++)
        m_irq[t] = (cand[t] != 0);
    if (rd && region == 1 && ofs == 0 && count != 0)
        void'(m_fifo.pop_front());
    if (count < RNG_DEPTH)
    begin
        m_fifo.push_back(m_lfsr);               // Push and step while not full
        m_lfsr = lfsr_advance(m_lfsr);
    end
endtask

`endif

// ==== tests/periph_tb.sv ====
/* Testbench for periph_top: random traffic from a fixed seed checked
   against a cycle model; one request may be issued every cycle */
`default_nettype none

module periph_tb
    import periph_map_pkg::*;
    import periph_irq_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PLANNED_OPS    = 1800;
    localparam int TIMEOUT_CYCLES = 4 * PLANNED_OPS + 200;

    logic                   clk_i;
    logic                   reset_i;
    bus_req_t               req_i;
    bus_resp_t              resp_o;
    logic [7:0]             dip_sw;
    logic [7:0]             leds_o;
    logic [NUM_TARGETS-1:0] irq_o;

    logic [31:0] lcg_state;
    int          cycle_count;
    int          errors;
    string       cur_test;
    logic [7:0]  dip_cur;
    bus_resp_t   prev_exp;

    `include "periph_model.svh"

    periph_top periph_top_inst (
        .clk_i          ( clk_i   ),
        .reset_i        ( reset_i ),
        .req_i          ( req_i   ),
        .resp_o         ( resp_o  ),
        .dip_switches_i ( dip_sw  ),
        .leds_o         ( leds_o  ),
        .irq_o          ( irq_o   )
    );

    always #50 clk_i = ~clk_i;

    always @(posedge clk_i)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("The run timed out after %0d cycles", cycle_count);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act)
        else
        begin
            errors++;
            $display("ERROR %s %s: expected %h, actual %h", cur_test, what, exp, act);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    endtask

    // ------------------------------------------------------------------------
    // Drive one request at a rising edge and check the previous response
    // ------------------------------------------------------------------------
    task automatic issue(input logic valid, input bus_op_e op, input logic [11:0] addr,
                         input logic [31:0] wdata);
        bus_req_t   r;
        bus_resp_t  exp;
        logic [7:0] led_exp;
        logic [1:0] irq_exp;
        r       = '{valid: valid, op: op, addr: addr, wdata: wdata};
        req_i  <= r;
        dip_sw <= dip_cur;
        led_exp = m_leds;                       // State after the current edge
        irq_exp = m_irq;
        step_model(r, dip_cur, exp);
        @(negedge clk_i);
        check_value("ready", 32'(prev_exp.ready), 32'(resp_o.ready));
        check_value("error", 32'(prev_exp.error), 32'(resp_o.error));
        if (prev_exp.ready)
            check_value("rdata", prev_exp.rdata, resp_o.rdata);
        check_value("leds_o", 32'(led_exp), 32'(leds_o));
        check_value("irq_o", 32'(irq_exp), 32'(irq_o));
        prev_exp = exp;
        @(posedge clk_i);
    endtask

    task automatic write_reg(input logic [11:0] addr, input logic [31:0] data);
        issue(1'b1, BUS_WRITE, addr, data);
    endtask

    task automatic read_reg(input logic [11:0] addr);
        issue(1'b1, BUS_READ, addr, 32'h0);
    endtask

    task automatic idle(input int n);
        repeat (n) issue(1'b0, BUS_READ, 12'h0, 32'h0);
    endtask

    initial
    begin
        logic [31:0] r;
        logic [3:0]  region;
        clk_i       = 1'b0;
        reset_i     = 1'b1;
        req_i       = '0;
        dip_sw      = '0;
        dip_cur     = '0;
        lcg_state   = 32'd51;
        cycle_count = 0;
        errors      = 0;
        prev_exp    = '0;
        reset_model();
        repeat (4) @(posedge clk_i);
        reset_i <= 1'b0;

        cur_test = "rng_empty";                 // FIFO still empty right after reset
        read_reg(12'h100);
        read_reg(12'h104);

        cur_test = "gpio";
        for (int i = 0; i < 30; i++)
        begin
            r = lcg_next();
            dip_cur = r[15:8];
            write_reg(r[31] ? 12'h000 : 12'h008, lcg_next());
            read_reg(12'h000);
            read_reg(12'h008);
            read_reg(12'h004);
        end

        cur_test = "unmapped";
        for (int i = 0; i < 30; i++)
        begin
            r = lcg_next();
            region = 4'(3 + r[31:24] % 13);
            issue(1'b1, bus_op_e'(r[23]), {region, r[7:2], 2'b00}, lcg_next());
        end

        cur_test = "rng_fill";
        idle(16);
        read_reg(12'h104);
        for (int i = 0; i < 12; i++)
            read_reg(12'h100);

        cur_test = "irq";
        write_reg(12'h008, 32'hFF);
        dip_cur = 8'h5A;
        for (int s = 1; s <= 2; s++)
            write_reg(12'(12'h200 + 4 * s), 32'(1 + lcg_next() % 7));
        for (int t = 0; t < 2; t++)
        begin
            write_reg(12'(12'h220 + 4 * t), lcg_next());
            write_reg(12'(12'h240 + 4 * t), 32'(lcg_next() % 4));
        end
        idle(2);
        for (int t = 0; t < 2; t++)
        begin
            read_reg(12'(12'h260 + 4 * t));
            read_reg(12'(12'h260 + 4 * t));
        end
        write_reg(12'h260, 32'd1);              // Complete both sources
        write_reg(12'h264, 32'd2);
        idle(2);
        read_reg(12'h260);
        read_reg(12'h264);

        cur_test = "random_mix";
        for (int i = 0; i < 1500; i++)
        begin
            r = lcg_next();
            region = r[31:28];
            if (region > 2 && r[27:25] != 0)
                region = 4'(r[24:23] % 3);      // Mostly mapped regions
            if (r[13:11] == 0)
                dip_cur = r[10:3];
            issue(r[16:14] != 0, bus_op_e'(r[17]), {region, 1'b0, r[22:18], 2'b00}, lcg_next());
        end
        idle(2);

        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+tests
hdl/periph_map_pkg.sv
hdl/periph_irq_pkg.sv
hdl/periph_decoder.sv
hdl/gpio_regs.sv
hdl/rng_fifo.sv
hdl/irq_controller.sv
hdl/periph_top.sv
tests/periph_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module periph_tb -f project.f
output=$(./obj_dir/Vperiph_tb)
echo "$output"

grep -q "Simulation finished: PASS" <<< "$output"
echo "run.sh: simulation passed"
